// File: norm_dims_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Group and beat geometry for the group norm engine
// The compute tile must divide the plane evenly
// NUM_VALUES must be a power of two, since the mean and variance divide by shift
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package norm_dims_pkg;

    // Plane and beat shape
    localparam int TOTAL_DIM0     = 4;
    localparam int TOTAL_DIM1     = 4;
    localparam int COMPUTE_DIM0   = 2;
    localparam int COMPUTE_DIM1   = 2;

    // Channel count for layer norm, 1 for instance norm
    localparam int GROUP_CHANNELS = 2;

    localparam int DEPTH_DIM0      = TOTAL_DIM0 / COMPUTE_DIM0;
    localparam int DEPTH_DIM1      = TOTAL_DIM1 / COMPUTE_DIM1;
    localparam int LANES           = COMPUTE_DIM0 * COMPUTE_DIM1;
    localparam int NUM_ITERS       = DEPTH_DIM0 * DEPTH_DIM1 * GROUP_CHANNELS;
    localparam int NUM_VALUES      = TOTAL_DIM0 * TOTAL_DIM1 * GROUP_CHANNELS;
    localparam int LOG2_NUM_VALUES = $clog2(NUM_VALUES);
    localparam int ITER_WIDTH      = $clog2(NUM_ITERS);

endpackage

// File: norm_fixed_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Fixed-point formats for the group norm engine
// All samples are two's complement; the inverse root code is unsigned
// Output cast floors and saturates, with no symmetric clipping
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package norm_fixed_pkg;

    localparam int IN_WIDTH            = 8;
    localparam int IN_FRAC_WIDTH       = 2;
    localparam int OUT_WIDTH           = 8;
    localparam int OUT_FRAC_WIDTH      = 4;

    // Difference keeps the input fraction, square doubles it
    localparam int DIFF_WIDTH          = IN_WIDTH + 1;
    localparam int SQ_WIDTH            = 2 * DIFF_WIDTH;
    localparam int SQ_FRAC_WIDTH       = 2 * IN_FRAC_WIDTH;
    localparam int SUM_WIDTH           = IN_WIDTH + norm_dims_pkg::LOG2_NUM_VALUES;
    localparam int SQ_SUM_WIDTH        = SQ_WIDTH + norm_dims_pkg::LOG2_NUM_VALUES;
    localparam int VAR_WIDTH           = SQ_SUM_WIDTH - norm_dims_pkg::LOG2_NUM_VALUES;

    localparam int INV_SQRT_WIDTH      = 16;
    localparam int INV_SQRT_FRAC_WIDTH = 10;

    // Root search compares root^2 * var against one at this fraction
    localparam int TRIAL_WIDTH         = 2 * INV_SQRT_WIDTH + VAR_WIDTH;
    localparam int ROOT_CMP_FRAC       = 2 * INV_SQRT_FRAC_WIDTH + SQ_FRAC_WIDTH;

    // Product of difference and root, then floor shift to output fraction
    localparam int NORM_WIDTH          = INV_SQRT_WIDTH + 1 + DIFF_WIDTH;
    localparam int NORM_FRAC_WIDTH     = INV_SQRT_FRAC_WIDTH + IN_FRAC_WIDTH;
    localparam int CAST_SHIFT          = NORM_FRAC_WIDTH - OUT_FRAC_WIDTH;
    localparam int OUT_MAX             = 2 ** (OUT_WIDTH - 1) - 1;
    localparam int OUT_MIN             = -(2 ** (OUT_WIDTH - 1));

    typedef logic signed [IN_WIDTH-1:0]   in_lane_t;
    typedef logic signed [DIFF_WIDTH-1:0] diff_lane_t;
    typedef logic signed [SQ_WIDTH-1:0]   sq_lane_t;
    typedef logic signed [OUT_WIDTH-1:0]  out_lane_t;

    typedef in_lane_t   [norm_dims_pkg::LANES-1:0] in_beat_t;
    typedef diff_lane_t [norm_dims_pkg::LANES-1:0] diff_beat_t;
    typedef sq_lane_t   [norm_dims_pkg::LANES-1:0] sq_beat_t;
    typedef out_lane_t  [norm_dims_pkg::LANES-1:0] out_beat_t;

endpackage

// File: stream_if.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Valid/ready beat stream with a last-beat flag
// A beat moves on a clock edge with valid and ready both high
// The source keeps data, valid and last steady until then
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

interface stream_if #(
    parameter type payload_t = logic
);

    payload_t data;
    logic     valid;
    logic     ready;
    // Final beat of a group
    logic     last;

    modport source (output data, output valid, output last, input ready);
    modport sink   (input data, input valid, input last, output ready);

endinterface

// File: matrix_fifo.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Synchronous FIFO of whole beats, last flag stored per entry
// Read data is combinational from the head entry
// No bypass, so a write is visible one cycle later at the earliest
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module matrix_fifo #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = 16
) (
    input  logic     clk,
    input  logic     rst,
    stream_if.sink   wr,
    stream_if.source rd
);

    localparam int PTR_WIDTH = $clog2(DEPTH);

    payload_t             mem      [DEPTH];
    logic                 last_mem [DEPTH];
    logic [PTR_WIDTH-1:0] wr_ptr;
    logic [PTR_WIDTH-1:0] rd_ptr;
    logic [PTR_WIDTH:0]   count;
    logic                 wr_fire;
    logic                 rd_fire;

    assign wr.ready = count != (PTR_WIDTH+1)'(DEPTH);
    assign rd.valid = count != '0;
    assign rd.data  = mem[rd_ptr];
    assign rd.last  = last_mem[rd_ptr];
    assign wr_fire  = wr.valid && wr.ready;
    assign rd_fire  = rd.valid && rd.ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_fire) begin
                wr_ptr <= (wr_ptr == PTR_WIDTH'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_fire) begin
                rd_ptr <= (rd_ptr == PTR_WIDTH'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + (PTR_WIDTH+1)'(wr_fire) - (PTR_WIDTH+1)'(rd_fire);
        end
    end

    always_ff @(posedge clk) begin
        if (wr_fire) begin
            mem[wr_ptr]      <= wr.data;
            last_mem[wr_ptr] <= wr.last;
        end
    end

    // Pointers meet only when empty or full, so a write never lands on unread data
    a_ptrs_match_count: assert property (@(posedge clk) disable iff (rst)
        (wr_ptr == rd_ptr) == (count == '0 || count == (PTR_WIDTH+1)'(DEPTH)));

endmodule

// File: group_accumulator.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Group total of all lanes over all beats of a group
// Total is valid the cycle after the last beat and held until taken
// Input is refused while a total waits
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module group_accumulator #(
    parameter int LANE_WIDTH    = norm_fixed_pkg::IN_WIDTH,
    parameter int SUM_OUT_WIDTH = norm_fixed_pkg::SUM_WIDTH
) (
    input  logic                            clk,
    input  logic                            rst,
    stream_if.sink                          beats,
    output logic signed [SUM_OUT_WIDTH-1:0] sum,
    output logic                            sum_valid,
    input  logic                            sum_ready
);

    import norm_dims_pkg::*;

    logic signed [SUM_OUT_WIDTH-1:0] acc;
    logic signed [SUM_OUT_WIDTH-1:0] beat_total;
    logic [ITER_WIDTH-1:0]           beat_cnt;
    logic                            beat_fire;

    assign beats.ready = !sum_valid;
    assign beat_fire   = beats.valid && beats.ready;

    // Lane adder for one beat
    always_comb begin
        logic signed [LANE_WIDTH-1:0] lane;
        beat_total = '0;
        for (int i = 0; i < LANES; i++) begin
            lane       = beats.data[i];
            beat_total = beat_total + lane;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            acc       <= '0;
            sum_valid <= 1'b0;
            beat_cnt  <= '0;
        end else begin
            if (sum_valid && sum_ready) begin
                sum_valid <= 1'b0;
            end
            if (beat_fire) begin
                beat_cnt <= beats.last ? '0 : beat_cnt + 1'b1;
                if (beats.last) begin
                    acc       <= '0;
                    sum_valid <= 1'b1;
                end else begin
                    acc <= acc + beat_total;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (beat_fire && beats.last) begin
            sum <= acc + beat_total;
        end
    end

    a_last_spacing: assert property (@(posedge clk) disable iff (rst)
        beat_fire |-> beats.last == (beat_cnt == ITER_WIDTH'(NUM_ITERS - 1)));

endmodule

// File: centering_stage.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Subtracts the group mean and squares the difference per lane
// Mean is the group total floor-shifted by log2 of the sample count
// Both outputs are registered, one cycle after the sample beat
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module centering_stage (
    input  logic                                       clk,
    input  logic                                       rst,
    input  logic signed [norm_fixed_pkg::SUM_WIDTH-1:0] mean_sum,
    input  logic                                       mean_valid,
    output logic                                       mean_ready,
    stream_if.sink                                     samples,
    stream_if.source                                   diffs,
    stream_if.source                                   squares
);

    import norm_dims_pkg::*;
    import norm_fixed_pkg::*;

    in_lane_t   mean;
    logic       mean_held;
    diff_beat_t diff_next;
    sq_beat_t   sq_next;
    logic       diff_pend;
    logic       sq_pend;
    logic       last_q;
    logic       out_free;
    logic       in_fire;

    // New mean accepted once the previous group has fully passed
    assign mean_ready    = !mean_held;
    assign out_free      = (!diff_pend || diffs.ready) && (!sq_pend || squares.ready);
    assign samples.ready = mean_held && out_free;
    assign in_fire       = samples.valid && samples.ready;

    assign diffs.valid   = diff_pend;
    assign squares.valid = sq_pend;
    assign diffs.last    = last_q;
    assign squares.last  = last_q;

    always_comb begin
        for (int i = 0; i < LANES; i++) begin
            diff_next[i] = $signed(samples.data[i]) - mean;
            sq_next[i]   = $signed(diff_next[i]) * $signed(diff_next[i]);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mean_held <= 1'b0;
            diff_pend <= 1'b0;
            sq_pend   <= 1'b0;
        end else begin
            if (mean_valid && mean_ready) begin
                mean_held <= 1'b1;
            end else if (in_fire && samples.last) begin
                mean_held <= 1'b0;
            end
            if (in_fire) begin
                diff_pend <= 1'b1;
                sq_pend   <= 1'b1;
            end else begin
                if (diffs.ready) diff_pend <= 1'b0;
                if (squares.ready) sq_pend <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (mean_valid && mean_ready) begin
            mean <= in_lane_t'(mean_sum >>> LOG2_NUM_VALUES);
        end
        if (in_fire) begin
            diffs.data   <= diff_next;
            squares.data <= sq_next;
            last_q       <= samples.last;
        end
    end

endmodule

// File: inv_sqrt_unit.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Bit-serial inverse square root of the group variance
// Result is the largest code whose square times the variance is at most one
// Zero variance saturates to all ones; latency is INV_SQRT_WIDTH + 1 cycles
// Result is held until inv_done
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module inv_sqrt_unit (
    input  logic                                           clk,
    input  logic                                           rst,
    input  logic signed [norm_fixed_pkg::SQ_SUM_WIDTH-1:0] var_sum,
    input  logic                                           var_valid,
    output logic                                           var_ready,
    output logic [norm_fixed_pkg::INV_SQRT_WIDTH-1:0]      inv_sqrt,
    output logic                                           inv_valid,
    input  logic                                           inv_done
);

    import norm_dims_pkg::*;
    import norm_fixed_pkg::*;

    typedef enum logic [1:0] {IDLE, SEARCH, FINISH, HOLD} state_t;

    state_t                              state;
    logic [VAR_WIDTH-1:0]                variance;
    logic [INV_SQRT_WIDTH-1:0]           root;
    logic [INV_SQRT_WIDTH-1:0]           trial_root;
    logic [$clog2(INV_SQRT_WIDTH)-1:0]   bit_idx;
    logic [TRIAL_WIDTH-1:0]              trial;
    logic [TRIAL_WIDTH-1:0]              held_sq;
    logic [TRIAL_WIDTH-1:0]              next_sq;

    assign var_ready = state == IDLE;
    assign inv_valid = state == HOLD;

    // Candidate with the current bit set, squared and scaled by the variance
    always_comb begin
        trial_root          = root;
        trial_root[bit_idx] = 1'b1;
        trial = TRIAL_WIDTH'(trial_root) * TRIAL_WIDTH'(trial_root) * TRIAL_WIDTH'(variance);
    end

    // Held result and the code just above it, both scaled by the variance
    assign held_sq = TRIAL_WIDTH'(inv_sqrt) * TRIAL_WIDTH'(inv_sqrt) * TRIAL_WIDTH'(variance);
    assign next_sq = (TRIAL_WIDTH'(inv_sqrt) + 1'b1) * (TRIAL_WIDTH'(inv_sqrt) + 1'b1)
                     * TRIAL_WIDTH'(variance);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE:    if (var_valid) state <= SEARCH;
                SEARCH:  if (bit_idx == '0) state <= FINISH;
                FINISH:  state <= HOLD;
                HOLD:    if (inv_done) state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && var_valid) begin
            variance <= VAR_WIDTH'(var_sum >>> LOG2_NUM_VALUES);
            root     <= '0;
            bit_idx  <= $bits(bit_idx)'(INV_SQRT_WIDTH - 1);
        end else if (state == SEARCH) begin
            if (trial <= (TRIAL_WIDTH'(1) << ROOT_CMP_FRAC)) begin
                root[bit_idx] <= 1'b1;
            end
            bit_idx <= bit_idx - 1'b1;
        end else if (state == FINISH) begin
            inv_sqrt <= root;
        end
    end

    // Held root meets the rule and the next code up would break it
    a_root_rule: assert property (@(posedge clk) disable iff (rst)
        inv_valid |-> held_sq <= (TRIAL_WIDTH'(1) << ROOT_CMP_FRAC)
            && (&inv_sqrt || next_sq > (TRIAL_WIDTH'(1) << ROOT_CMP_FRAC)));

endmodule

// File: norm_scaler.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Scales stored differences by the group inverse root
// Product register then output register, two cycles from the FIFO read
// Cast floors to the output fraction and saturates to the output width
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module norm_scaler (
    input  logic                                      clk,
    input  logic                                      rst,
    stream_if.sink                                    diffs,
    input  logic [norm_fixed_pkg::INV_SQRT_WIDTH-1:0] inv_sqrt,
    input  logic                                      inv_valid,
    output logic                                      inv_done,
    output norm_fixed_pkg::out_beat_t                 out_data,
    output logic                                      out_valid,
    input  logic                                      out_ready
);

    import norm_dims_pkg::*;
    import norm_fixed_pkg::*;

    logic signed [NORM_WIDTH-1:0] prod_q [LANES];
    logic                         prod_valid;
    logic                         out_free;
    logic                         prod_free;
    logic                         in_fire;
    out_beat_t                    cast_beat;

    assign out_free    = !out_valid || out_ready;
    assign prod_free   = !prod_valid || out_free;
    // Diffs wait until the root of their group is ready
    assign diffs.ready = inv_valid && prod_free;
    assign in_fire     = diffs.valid && diffs.ready;
    assign inv_done    = in_fire && diffs.last;

    always_comb begin
        logic signed [NORM_WIDTH-1:0] floored;
        for (int i = 0; i < LANES; i++) begin
            floored = prod_q[i] >>> CAST_SHIFT;
            if (floored > OUT_MAX) begin
                cast_beat[i] = out_lane_t'(OUT_MAX);
            end else if (floored < OUT_MIN) begin
                cast_beat[i] = out_lane_t'(OUT_MIN);
            end else begin
                cast_beat[i] = out_lane_t'(floored);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            prod_valid <= 1'b0;
            out_valid  <= 1'b0;
        end else begin
            if (in_fire) begin
                prod_valid <= 1'b1;
            end else if (out_free) begin
                prod_valid <= 1'b0;
            end
            if (out_free) out_valid <= prod_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_fire) begin
            for (int i = 0; i < LANES; i++) begin
                prod_q[i] <= $signed({1'b0, inv_sqrt}) * $signed(diffs.data[i]);
            end
        end
        if (out_free && prod_valid) begin
            out_data <= cast_beat;
        end
    end

    // Root of the head group stays put until its last diff beat is taken
    a_root_steady: assert property (@(posedge clk) disable iff (rst)
        inv_valid && !inv_done |=> inv_valid && $stable(inv_sqrt));

endmodule

// File: group_norm_2d.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Streaming group norm: mean pass, variance pass, scale pass
// Input beats must come in whole groups of NUM_ITERS beats
// No gamma/beta, no epsilon; output order follows input order
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module group_norm_2d (
    input  logic                      clk,
    input  logic                      rst,
    input  norm_fixed_pkg::in_lane_t  in_data  [norm_dims_pkg::LANES-1:0],
    input  logic                      in_valid,
    output logic                      in_ready,
    output norm_fixed_pkg::out_lane_t out_data [norm_dims_pkg::LANES-1:0],
    output logic                      out_valid,
    input  logic                      out_ready
);

    import norm_dims_pkg::*;
    import norm_fixed_pkg::*;

    stream_if #(.payload_t(in_beat_t))   in_fifo_wr ();
    stream_if #(.payload_t(in_beat_t))   in_fifo_rd ();
    stream_if #(.payload_t(in_beat_t))   mean_beats ();
    stream_if #(.payload_t(diff_beat_t)) diff_wr ();
    stream_if #(.payload_t(diff_beat_t)) diff_rd ();
    stream_if #(.payload_t(sq_beat_t))   sq_beats ();

    in_beat_t                    in_beat;
    out_beat_t                   out_beat;
    logic [ITER_WIDTH-1:0]       in_cnt;
    logic                        in_last;
    logic signed [SUM_WIDTH-1:0] mean_sum;
    logic                        mean_valid;
    logic                        mean_ready;
    logic signed [SQ_SUM_WIDTH-1:0] var_sum;
    logic                        var_valid;
    logic                        var_ready;
    logic [INV_SQRT_WIDTH-1:0]   inv_sqrt;
    logic                        inv_valid;
    logic                        inv_done;

    always_comb begin
        for (int i = 0; i < LANES; i++) begin
            in_beat[i]  = in_data[i];
            out_data[i] = out_beat[i];
        end
    end

    // Input goes to the FIFO and the mean accumulator together
    assign in_ready         = in_fifo_wr.ready && mean_beats.ready;
    assign in_fifo_wr.valid = in_valid && mean_beats.ready;
    assign mean_beats.valid = in_valid && in_fifo_wr.ready;
    assign in_fifo_wr.data  = in_beat;
    assign mean_beats.data  = in_beat;
    assign in_fifo_wr.last  = in_last;
    assign mean_beats.last  = in_last;
    assign in_last          = in_cnt == ITER_WIDTH'(NUM_ITERS - 1);

    always_ff @(posedge clk) begin
        if (rst) begin
            in_cnt <= '0;
        end else if (in_valid && in_ready) begin
            in_cnt <= in_last ? '0 : in_cnt + 1'b1;
        end
    end

    matrix_fifo #(.payload_t(in_beat_t), .DEPTH(2 * NUM_ITERS)) u_in_fifo (
        .clk(clk), .rst(rst), .wr(in_fifo_wr), .rd(in_fifo_rd)
    );

    group_accumulator #(.LANE_WIDTH(IN_WIDTH), .SUM_OUT_WIDTH(SUM_WIDTH)) u_mean_acc (
        .clk(clk), .rst(rst), .beats(mean_beats),
        .sum(mean_sum), .sum_valid(mean_valid), .sum_ready(mean_ready)
    );

    centering_stage u_center (
        .clk(clk), .rst(rst),
        .mean_sum(mean_sum), .mean_valid(mean_valid), .mean_ready(mean_ready),
        .samples(in_fifo_rd), .diffs(diff_wr), .squares(sq_beats)
    );

    matrix_fifo #(.payload_t(diff_beat_t), .DEPTH(NUM_ITERS)) u_diff_fifo (
        .clk(clk), .rst(rst), .wr(diff_wr), .rd(diff_rd)
    );

    group_accumulator #(.LANE_WIDTH(SQ_WIDTH), .SUM_OUT_WIDTH(SQ_SUM_WIDTH)) u_var_acc (
        .clk(clk), .rst(rst), .beats(sq_beats),
        .sum(var_sum), .sum_valid(var_valid), .sum_ready(var_ready)
    );

    inv_sqrt_unit u_inv_sqrt (
        .clk(clk), .rst(rst),
        .var_sum(var_sum), .var_valid(var_valid), .var_ready(var_ready),
        .inv_sqrt(inv_sqrt), .inv_valid(inv_valid), .inv_done(inv_done)
    );

    norm_scaler u_scaler (
        .clk(clk), .rst(rst), .diffs(diff_rd),
        .inv_sqrt(inv_sqrt), .inv_valid(inv_valid), .inv_done(inv_done),
        .out_data(out_beat), .out_valid(out_valid), .out_ready(out_ready)
    );

endmodule

// File: tb_group_norm_2d.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Self-checking testbench for group_norm_2d
// Integer model of the mean, variance, root search and output cast
// Beats are compared in order against a queue of expected beats
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module tb_group_norm_2d;

    import norm_dims_pkg::*;
    import norm_fixed_pkg::*;

    localparam int NUM_GROUPS     = 13;
    localparam int TIMEOUT_CYCLES = NUM_GROUPS * NUM_ITERS * 40 + 2000;
    localparam int CLK_PERIOD     = 20;
    localparam int DRIVE_DELAY    = 2;

    logic      clk;
    logic      rst;
    in_lane_t  in_data [LANES-1:0];
    logic      in_valid;
    logic      in_ready;
    out_lane_t out_data [LANES-1:0];
    logic      out_valid;
    logic      out_ready;

    logic [LANES*OUT_WIDTH-1:0] out_flat;
    logic [LANES*OUT_WIDTH-1:0] exp_front;
    logic                       exp_avail;
    logic [LANES*OUT_WIDTH-1:0] exp_q [$];
    logic [15:0]                sample_lfsr;
    logic [15:0]                stall_lfsr;
    logic                       stall_en;
    int                         grp [NUM_VALUES];
    int                         in_beats;
    int                         out_beats;
    int                         mismatches;
    int                         other_errors;

    group_norm_2d u_dut (
        .clk(clk), .rst(rst),
        .in_data(in_data), .in_valid(in_valid), .in_ready(in_ready),
        .out_data(out_data), .out_valid(out_valid), .out_ready(out_ready)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always_comb begin
        for (int i = 0; i < LANES; i++) begin
            out_flat[i*OUT_WIDTH +: OUT_WIDTH] = out_data[i];
        end
    end

    // 16-bit Galois LFSR with taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    function automatic logic [15:0] sample_bits(input int n);
        logic [15:0] bits;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            sample_lfsr = lfsr_step(sample_lfsr);
            bits        = {bits[14:0], sample_lfsr[0]};
        end
        return bits;
    endfunction

    function automatic logic stall_bit();
        stall_lfsr = lfsr_step(stall_lfsr);
        return stall_lfsr[0];
    endfunction

    // Largest code y with y * y * variance at most one, at fraction 24
    function automatic longint root_search(input longint variance);
        longint y;
        longint t;
        y = 0;
        for (int b = INV_SQRT_WIDTH - 1; b >= 0; b--) begin
            t = y | (longint'(1) << b);
            if (t * t * variance <= (longint'(1) << 24)) begin
                y = t;
            end
        end
        return y;
    endfunction

    // Fraction 12 product floored to fraction 4, then clipped to 8 bits
    function automatic logic [OUT_WIDTH-1:0] cast_out(input longint prod);
        longint floored;
        floored = prod >>> 8;
        if (floored > 127) begin
            floored = 127;
        end else if (floored < -128) begin
            floored = -128;
        end
        return floored[OUT_WIDTH-1:0];
    endfunction

    function automatic void refresh_front();
        exp_avail = exp_q.size() > 0;
        exp_front = exp_avail ? exp_q[0] : '0;
    endfunction

    task automatic push_expected();
        int                         sum;
        int                         mean;
        longint                     sq_sum;
        longint                     root;
        logic [LANES*OUT_WIDTH-1:0] beat;
        sum    = 0;
        sq_sum = 0;
        foreach (grp[i]) begin
            sum += grp[i];
        end
        mean = sum >>> LOG2_NUM_VALUES;
        foreach (grp[i]) begin
            sq_sum += (grp[i] - mean) * (grp[i] - mean);
        end
        root = root_search(sq_sum >>> LOG2_NUM_VALUES);
        for (int b = 0; b < NUM_ITERS; b++) begin
            for (int l = 0; l < LANES; l++) begin
                beat[l*OUT_WIDTH +: OUT_WIDTH] = cast_out((grp[b*LANES+l] - mean) * root);
            end
            exp_q.push_back(beat);
        end
        refresh_front();
    endtask

    task automatic fill_random();
        in_lane_t v;
        for (int i = 0; i < NUM_VALUES; i++) begin
            v      = in_lane_t'(sample_bits(8));
            grp[i] = v;
        end
    endtask

    // Sends grp as one group with sample b*LANES+l in lane l of beat b
    task automatic drive_group();
        push_expected();
        for (int b = 0; b < NUM_ITERS; b++) begin
            for (int l = 0; l < LANES; l++) begin
                in_data[l] = in_lane_t'(grp[b*LANES+l]);
            end
            in_valid = 1'b1;
            do begin
                @(posedge clk);
            end while (!in_ready);
            in_beats++;
            #DRIVE_DELAY;
        end
        in_valid = 1'b0;
    endtask

    task automatic wait_drain();
        wait (out_beats == in_beats);
        repeat (20) @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic close_run();
        $display("Checks done: %0d mismatches, %0d other errors, %0d beats in, %0d beats out",
                 mismatches, other_errors, in_beats, out_beats);
        if (mismatches + other_errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    endtask

    // Output consumer side
    always @(posedge clk) begin
        if (!rst && out_valid && out_ready) begin
            out_beats++;
            if (exp_q.size() > 0) begin
                void'(exp_q.pop_front());
            end
            refresh_front();
        end
    end

    initial begin
        logic stall_now;
        out_ready = 1'b1;
        forever begin
            @(posedge clk);
            stall_now = stall_en;
            #DRIVE_DELAY;
            out_ready = stall_now ? stall_bit() : 1'b1;
        end
    end

    a_reset_idle: assert property (@(posedge clk) $fell(rst) |-> !out_valid && in_ready)
        else begin
            other_errors++;
            $display("Error at %0t: out_valid or in_ready wrong right after reset", $time);
        end

    a_expected_beat: assert property (@(posedge clk) disable iff (rst)
        out_valid |-> exp_avail)
        else begin
            other_errors++;
            $display("Error at %0t: output beat arrived with no beat expected", $time);
        end

    a_output_value: assert property (@(posedge clk) disable iff (rst)
        out_valid && out_ready && exp_avail |-> out_flat == exp_front)
        else begin
            mismatches++;
            $display("Mismatch at %0t: out_data %h, expected %h",
                     $time, $sampled(out_flat), $sampled(exp_front));
        end

    a_stall_hold: assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(out_flat))
        else begin
            mismatches++;
            $display("Mismatch at %0t: out_data or out_valid moved while stalled", $time);
        end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        other_errors++;
        $display("Error: timeout after %0d cycles, output stream never drained",
                 TIMEOUT_CYCLES);
        close_run();
    end

    initial begin
        rst          = 1'b1;
        in_valid     = 1'b0;
        stall_en     = 1'b0;
        sample_lfsr  = 16'd19;
        stall_lfsr   = 16'd19;
        in_beats     = 0;
        out_beats    = 0;
        mismatches   = 0;
        other_errors = 0;
        exp_avail    = 1'b0;
        exp_front    = '0;
        for (int l = 0; l < LANES; l++) begin
            in_data[l] = '0;
        end
        repeat (10) @(posedge clk);
        #DRIVE_DELAY;
        rst = 1'b0;
        @(posedge clk);
        #DRIVE_DELAY;

        // One random group, no stalls
        fill_random();
        drive_group();
        wait_drain();

        // Constant group, zero variance
        foreach (grp[i]) begin
            grp[i] = -37;
        end
        drive_group();
        wait_drain();

        // Two opposite samples floor the variance to zero, so products overflow
        foreach (grp[i]) begin
            grp[i] = 0;
        end
        grp[5]  = 2;
        grp[22] = -2;
        drive_group();
        wait_drain();

        // Back-to-back groups with random output stalls
        stall_en = 1'b1;
        repeat (10) begin
            fill_random();
            drive_group();
        end
        wait_drain();
        stall_en = 1'b0;
        repeat (50) @(posedge clk);

        a_beat_count: assert (out_beats == in_beats && exp_q.size() == 0)
            else begin
                other_errors++;
                $display("Error: %0d beats went in but %0d came out", in_beats, out_beats);
            end
        close_run();
    end

endmodule

// File: flist.f
norm_dims_pkg.sv
norm_fixed_pkg.sv
stream_if.sv
matrix_fifo.sv
group_accumulator.sv
centering_stage.sv
inv_sqrt_unit.sv
norm_scaler.sv
group_norm_2d.sv
tb_group_norm_2d.sv
